/* attn_params.svh */
`ifndef ATTN_PARAMS_SVH
`define ATTN_PARAMS_SVH

// tile geometry
`define ATTN_ROWS        16          // rows per tile, one unit each
`define ATTN_COLS        16          // scores per row

// fixed-point formats
`define ATTN_DW          16          // score and probability word
`define ATTN_FRAC        8           // q8.8 score fraction bits
`define ATTN_SUM_W       24          // running sum, 16 fraction bits

// 724 / 2^13 ~ 1/sqrt(128)
`define ATTN_SCALE       724
`define ATTN_SCALE_SHIFT 13

`define ATTN_M_INIT      16'h8000    // most negative max
`define ATTN_LAT         3           // score_vld_i to prob_vld_o

`endif

/* attn_pkg.sv */
`default_nettype none
`include "attn_params.svh"

package attn_pkg;

    localparam int ROW_IW = $clog2(`ATTN_ROWS);      // row index width
    localparam int INT_W  = `ATTN_DW - `ATTN_FRAC;   // integer bits of a score

    ////////////////////////////////////////////////////////////
    // fixed-point word
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [INT_W-1:0]      int_part;
        logic [`ATTN_FRAC-1:0] frac_part;
    } fx_parts_t;

    // read as a signed score or split at the binary point
    typedef union packed {
        logic signed [`ATTN_DW-1:0] raw;
        fx_parts_t                  parts;
    } fx_word_t;

    typedef logic signed [`ATTN_DW-1:0] score_word_t;
    typedef logic [`ATTN_DW-1:0]        prob_word_t;   // unsigned q0.16

    ////////////////////////////////////////////////////////////
    // row bundles
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [ROW_IW-1:0]                 idx;
        score_word_t [`ATTN_COLS-1:0]      score;
    } score_row_t;

    typedef struct packed {
        logic [ROW_IW-1:0]                 idx;
        fx_word_t [`ATTN_COLS-1:0]         score;   // after 1/sqrt(d_k)
    } scaled_row_t;

    typedef struct packed {
        logic [ROW_IW-1:0]                 idx;
        prob_word_t [`ATTN_COLS-1:0]       prob;    // unnormalised
        prob_word_t                        coef;    // rescale for old output
        logic [`ATTN_SUM_W-1:0]            sum;     // running exp sum
    } prob_row_t;

endpackage

`default_nettype wire

/* score_dispatch.sv */
`timescale 1ns/10ps
`default_nettype none
`include "attn_params.svh"

module score_dispatch
    import attn_pkg::*;
(
    input  logic                  I_CLK,
    input  logic                  I_RST_N,
    input  logic                  blk_start_i,
    input  logic                  score_vld_i,
    input  score_row_t            score_i,
    output logic                  blk_clr_o,
    output logic [`ATTN_ROWS-1:0] sel_vld_o,
    output scaled_row_t           scaled_row_o
);

    localparam logic signed [31:0] SCALE   = `ATTN_SCALE;
    localparam logic signed [31:0] SAT_MAX = 32'sd32767;
    localparam logic signed [31:0] SAT_MIN = -32'sd32768;

    logic signed [31:0]    prod [`ATTN_COLS];
    logic signed [31:0]    shft [`ATTN_COLS];
    scaled_row_t           scaled;
    logic [`ATTN_ROWS-1:0] sel;

    // scale each score, floor the shift, clip to q8.8
    always_comb begin
        scaled.idx = score_i.idx;
        for (int c = 0; c < `ATTN_COLS; c++) begin
            prod[c] = $signed(score_i.score[c]) * SCALE;
            shft[c] = prod[c] >>> `ATTN_SCALE_SHIFT;   // arithmetic, rounds down
            if (shft[c] > SAT_MAX) begin
                scaled.score[c].raw = 16'sh7fff;
            end else if (shft[c] < SAT_MIN) begin
                scaled.score[c].raw = 16'sh8000;
            end else begin
                scaled.score[c].raw = shft[c][`ATTN_DW-1:0];
            end
        end
    end

    assign sel = score_vld_i ? ({{(`ATTN_ROWS-1){1'b0}}, 1'b1} << score_i.idx) : '0;

    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            blk_clr_o <= 1'b0;
            sel_vld_o <= '0;
        end else begin
            blk_clr_o <= blk_start_i;    // stays aligned with the row
            sel_vld_o <= sel;
        end
    end

    always_ff @(posedge I_CLK) begin
        if (score_vld_i) begin
            scaled_row_o <= scaled;
        end
    end

endmodule

`default_nettype wire

/* row_softmax.sv */
`timescale 1ns/10ps
`default_nettype none
`include "attn_params.svh"

module row_softmax
    import attn_pkg::*;
(
    input  logic        I_CLK,
    input  logic        I_RST_N,
    input  logic        blk_clr_i,
    input  logic        vld_i,
    input  scaled_row_t scaled_row_i,
    output logic        vld_o,
    output prob_row_t   row_o
);

    localparam logic signed [`ATTN_DW-1:0] M_INIT = `ATTN_M_INIT;
    localparam int                         TREE_N = 2 * `ATTN_COLS - 1;

    ////////////////////////////////////////////////////////////
    // arithmetic helpers
    ////////////////////////////////////////////////////////////

    // a - b with a <= b, clipped to the most negative word
    function automatic logic signed [`ATTN_DW-1:0] sub_sat(
        input logic signed [`ATTN_DW-1:0] a,
        input logic signed [`ATTN_DW-1:0] b
    );
        logic signed [`ATTN_DW:0] d;
        d = {a[`ATTN_DW-1], a} - {b[`ATTN_DW-1], b};
        if (d < -17'sd32768) begin
            return 16'sh8000;
        end
        return d[`ATTN_DW-1:0];
    endfunction

    // 2^d for d <= 0, linear in the fraction, shift by the integer
    function automatic logic [`ATTN_DW-1:0] exp2n(input logic signed [`ATTN_DW-1:0] d);
        fx_word_t            mag;
        logic [`ATTN_DW-1:0] mant;
        mag.raw = -d;
        mant    = {`ATTN_DW{1'b1}} - {1'b0, mag.parts.frac_part, 7'b0};
        if (mag.parts.int_part >= `ATTN_DW) begin
            return '0;
        end
        return mant >> mag.parts.int_part;
    endfunction

    logic signed [`ATTN_DW-1:0] m_q;                  // running max
    logic [`ATTN_SUM_W-1:0]     l_q;                  // running sum
    logic signed [`ATTN_DW-1:0] m_old;
    logic [`ATTN_SUM_W-1:0]     l_old;
    logic signed [`ATTN_DW-1:0] tree [TREE_N];        // heap-ordered max tree
    logic signed [`ATTN_DW-1:0] m_new;
    logic [`ATTN_DW+3:0]        psum;                 // 16 probs, no overflow
    logic [`ATTN_SUM_W+15:0]    l_prod;
    logic [`ATTN_SUM_W:0]       l_acc;
    prob_row_t                  res;

    ////////////////////////////////////////////////////////////
    // row update
    ////////////////////////////////////////////////////////////

    always_comb begin
        m_old = blk_clr_i ? M_INIT : m_q;   // clear with row uses fresh state
        l_old = blk_clr_i ? '0 : l_q;

        for (int c = 0; c < `ATTN_COLS; c++) begin
            tree[`ATTN_COLS-1+c] = scaled_row_i.score[c].raw;
        end
        for (int n = `ATTN_COLS - 2; n >= 0; n--) begin
            tree[n] = (tree[2*n+1] > tree[2*n+2]) ? tree[2*n+1] : tree[2*n+2];
        end
        m_new = (tree[0] > m_old) ? tree[0] : m_old;

        res.idx = scaled_row_i.idx;
        psum    = '0;
        for (int c = 0; c < `ATTN_COLS; c++) begin
            res.prob[c] = exp2n(sub_sat(scaled_row_i.score[c].raw, m_new));
            psum        = psum + res.prob[c];
        end

        // first tile of a block has nothing to rescale
        res.coef = (m_old == M_INIT) ? '0 : exp2n(sub_sat(m_old, m_new));

        l_prod  = l_old * res.coef;
        l_acc   = {1'b0, l_prod[`ATTN_SUM_W+15:16]} + psum;
        res.sum = l_acc[`ATTN_SUM_W] ? {`ATTN_SUM_W{1'b1}} : l_acc[`ATTN_SUM_W-1:0];
    end

    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            vld_o <= 1'b0;
            m_q   <= M_INIT;
            l_q   <= '0;
        end else begin
            vld_o <= vld_i;
            if (vld_i) begin
                m_q <= m_new;
                l_q <= res.sum;
            end else if (blk_clr_i) begin
                m_q <= M_INIT;         // new block, no row for us
                l_q <= '0;
            end
        end
    end

    always_ff @(posedge I_CLK) begin
        if (vld_i) begin
            row_o <= res;
        end
    end

endmodule

`default_nettype wire

/* prob_collect.sv */
`timescale 1ns/10ps
`default_nettype none
`include "attn_params.svh"

module prob_collect
    import attn_pkg::*;
(
    input  logic                  I_CLK,
    input  logic                  I_RST_N,
    input  logic [`ATTN_ROWS-1:0] unit_vld_i,
    input  prob_row_t             unit_row_i [0:`ATTN_ROWS-1],
    output logic                  prob_vld_o,
    output prob_row_t             prob_o
);

    logic      any_vld;
    prob_row_t sel_row;

    assign any_vld = |unit_vld_i;

    // and-or mux, at most one unit fires per cycle
    always_comb begin
        sel_row = '0;
        for (int u = 0; u < `ATTN_ROWS; u++) begin
            if (unit_vld_i[u]) begin
                sel_row = sel_row | unit_row_i[u];
            end
        end
    end

    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            prob_vld_o <= 1'b0;
        end else begin
            prob_vld_o <= any_vld;
        end
    end

    always_ff @(posedge I_CLK) begin
        if (any_vld) begin
            prob_o <= sel_row;    // held while idle
        end
    end

endmodule

`default_nettype wire

/* attn_softmax_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "attn_params.svh"

module attn_softmax_top
    import attn_pkg::*;
(
    input  logic       I_CLK,
    input  logic       I_RST_N,
    input  logic       blk_start_i,
    input  logic       score_vld_i,
    input  score_row_t score_i,
    output logic       prob_vld_o,
    output prob_row_t  prob_o
);

    logic                  blk_clr;
    logic [`ATTN_ROWS-1:0] sel_vld;      // one-hot row select
    scaled_row_t           scaled_row;
    logic [`ATTN_ROWS-1:0] unit_vld;
    prob_row_t             unit_row [0:`ATTN_ROWS-1];

    ////////////////////////////////////////////////////////////
    // dispatch, per-row state, collect
    ////////////////////////////////////////////////////////////

    score_dispatch u_dispatch (
        .I_CLK        (I_CLK),
        .I_RST_N      (I_RST_N),
        .blk_start_i  (blk_start_i),
        .score_vld_i  (score_vld_i),
        .score_i      (score_i),
        .blk_clr_o    (blk_clr),
        .sel_vld_o    (sel_vld),
        .scaled_row_o (scaled_row)
    );

    for (genvar r = 0; r < `ATTN_ROWS; r++) begin : g_row
        row_softmax u_row (
            .I_CLK        (I_CLK),
            .I_RST_N      (I_RST_N),
            .blk_clr_i    (blk_clr),
            .vld_i        (sel_vld[r]),
            .scaled_row_i (scaled_row),
            .vld_o        (unit_vld[r]),
            .row_o        (unit_row[r])
        );
    end

    prob_collect u_collect (
        .I_CLK      (I_CLK),
        .I_RST_N    (I_RST_N),
        .unit_vld_i (unit_vld),
        .unit_row_i (unit_row),
        .prob_vld_o (prob_vld_o),
        .prob_o     (prob_o)
    );

endmodule

`default_nettype wire

/* attn_softmax_checker.sv */
`timescale 1ns/10ps
`default_nettype none
`include "attn_params.svh"

module attn_softmax_checker (
    input logic                  I_CLK,
    input logic                  I_RST_N,
    input logic                  score_vld_i,
    input logic                  prob_vld_i,
    input logic [`ATTN_ROWS-1:0] sel_vld_i
);

    a_latency: assert property (@(posedge I_CLK) disable iff (!I_RST_N)
        prob_vld_i == $past(score_vld_i, `ATTN_LAT))
        else $error("prob_vld_o does not follow score_vld_i by %0d cycles", `ATTN_LAT);

    a_vld_known: assert property (@(posedge I_CLK) disable iff (!I_RST_N)
        !$isunknown(prob_vld_i))
        else $error("prob_vld_o is unknown");

    a_sel_onehot: assert property (@(posedge I_CLK) disable iff (!I_RST_N)
        $past(score_vld_i) ? $onehot(sel_vld_i) : (sel_vld_i == '0))    // one unit per row
        else $error("dispatcher select does not match the accepted rows");

endmodule

bind attn_softmax_top attn_softmax_checker u_checker (
    .I_CLK       (I_CLK),
    .I_RST_N     (I_RST_N),
    .score_vld_i (score_vld_i),
    .prob_vld_i  (prob_vld_o),
    .sel_vld_i   (sel_vld)
);

`default_nettype wire

/* tb_attn_softmax.sv */
`timescale 1ns/10ps
`default_nettype none
`include "attn_params.svh"

module tb_attn_softmax
    import attn_pkg::*;
();

    localparam int RST_CYC  = 5;
    localparam int IDLE_CYC = 10;
    localparam int N_TILES  = 5;
    localparam int N_RAND   = 64;    // random rows, each may add one idle cycle
    localparam int TAIL_CYC = 5;
    localparam int STIM_CYC = RST_CYC + IDLE_CYC + N_TILES * `ATTN_ROWS + 2
                              + 2 * N_RAND + 1 + `ATTN_LAT + TAIL_CYC;
    localparam int TIMEOUT  = STIM_CYC + 20;
    localparam int M_INIT_I = -32768;
    localparam longint SUM_MAX = (64'd1 << `ATTN_SUM_W) - 1;
    localparam int MODE_MIX = 0, MODE_MID = 1, MODE_LARGE = 2, MODE_SMALL = 3;

    logic       I_CLK, I_RST_N, blk_start_i, score_vld_i, prob_vld_o;
    score_row_t score_i;
    prob_row_t  prob_o;
    int         m_model [`ATTN_ROWS];    // expected running max per row
    longint     l_model [`ATTN_ROWS];    // expected running sum per row
    prob_row_t  exp_q [$];
    int         due_q [$];               // cycle each result must appear
    int         cyc = 0;
    int         errors = 0;
    int         n_checked = 0;

    attn_softmax_top UUT (.*);

    initial I_CLK = 1'b0;
    always #2 I_CLK = ~I_CLK;

    always @(posedge I_CLK) begin
        cyc = cyc + 1;
        if (cyc > TIMEOUT) begin
            $display("timeout: results still missing after %0d cycles", TIMEOUT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic int scale_ref(input logic signed [15:0] s);
        int p;
        p = (int'(s) * `ATTN_SCALE) >>> `ATTN_SCALE_SHIFT;    // floor
        if (p > 32767) p = 32767;
        if (p < -32768) p = -32768;
        return p;
    endfunction

    function automatic int exp2n_ref(input int d);
        int mag, n, f;
        mag = -d;
        n   = mag >> `ATTN_FRAC;
        f   = mag % (1 << `ATTN_FRAC);
        if (n >= `ATTN_DW) return 0;
        return (65535 - f * 128) >> n;
    endfunction

    function automatic void clear_model();
        for (int r = 0; r < `ATTN_ROWS; r++) begin
            m_model[r] = M_INIT_I;
            l_model[r] = 0;
        end
    endfunction

    function automatic prob_row_t ref_row(input score_row_t s);
        prob_row_t r;
        int        sc [`ATTN_COLS];
        int        i, m_old, m_new, coef;
        longint    psum, l_new;
        i     = int'(s.idx);
        m_old = m_model[i];
        m_new = m_old;
        psum  = 0;
        for (int c = 0; c < `ATTN_COLS; c++) begin
            sc[c] = scale_ref(s.score[c]);
            if (sc[c] > m_new) m_new = sc[c];
        end
        r.idx = s.idx;
        for (int c = 0; c < `ATTN_COLS; c++) begin
            r.prob[c] = 16'(exp2n_ref(sc[c] - m_new));
            psum      = psum + longint'(r.prob[c]);
        end
        coef   = (m_old == M_INIT_I) ? 0 : exp2n_ref(m_old - m_new);   // nothing to rescale
        r.coef = 16'(coef);
        l_new  = ((l_model[i] * longint'(coef)) >>> 16) + psum;
        if (l_new > SUM_MAX) l_new = SUM_MAX;
        r.sum      = l_new[`ATTN_SUM_W-1:0];
        m_model[i] = m_new;
        l_model[i] = l_new;
        return r;
    endfunction

    function automatic score_row_t gen_row(input int idx, input int mode);
        score_row_t s;
        int         v;
        s.idx = 4'(idx);
        for (int c = 0; c < `ATTN_COLS; c++) begin
            case (mode)
                MODE_MIX: begin
                    v = int'($urandom % 8);
                    if (v == 0) v = 32767;                  // extremes
                    else if (v == 1) v = -32768;
                    else if (v < 4) v = int'($urandom % 65536) - 32768;
                    else v = int'($urandom % 8192) - 4096;
                end
                MODE_LARGE: v = 6000 + int'($urandom % 4096);
                MODE_SMALL: v = -6000 - int'($urandom % 4096);
                default:    v = int'($urandom % 8192) - 4096;
            endcase
            s.score[c] = 16'(v);
        end
        return s;
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus and compare
    ////////////////////////////////////////////////////////////

    task automatic drive_cycle(input logic start, input logic vld, input score_row_t s);
        @(negedge I_CLK);
        if (start) clear_model();                 // new block before its first row
        if (vld) begin
            exp_q.push_back(ref_row(s));
            due_q.push_back(cyc + `ATTN_LAT);
        end
        blk_start_i = start;
        score_vld_i = vld;
        score_i     = s;
    endtask

    task automatic send_tile(input int mode, input logic start_first);
        for (int r = 0; r < `ATTN_ROWS; r++) begin
            drive_cycle(start_first && (r == 0), 1'b1, gen_row(r, mode));
        end
    endtask

    task automatic check_row(input prob_row_t e, input prob_row_t a);
        if (a.idx !== e.idx) begin
            $display("error: prob_o.idx expected %h actual %h", e.idx, a.idx);
            errors++;
        end
        for (int c = 0; c < `ATTN_COLS; c++) begin
            if (a.prob[c] !== e.prob[c]) begin
                $display("error: prob_o.prob[%0d] row %h expected %h actual %h",
                         c, e.idx, e.prob[c], a.prob[c]);
                errors++;
            end
        end
        if (a.coef !== e.coef) begin
            $display("error: prob_o.coef row %h expected %h actual %h", e.idx, e.coef, a.coef);
            errors++;
        end
        if (a.sum !== e.sum) begin
            $display("error: prob_o.sum row %h expected %h actual %h", e.idx, e.sum, a.sum);
            errors++;
        end
    endtask

    always @(negedge I_CLK) begin
        if (I_RST_N && prob_vld_o) begin
            if (due_q.size() == 0 || due_q[0] > cyc) begin
                $display("unexpected output at cycle %0d with no row due", cyc);
                errors++;
            end else begin
                check_row(exp_q.pop_front(), prob_o);
                void'(due_q.pop_front());
                n_checked++;
            end
        end else if (I_RST_N && due_q.size() != 0 && due_q[0] == cyc) begin
            $display("missing output for a row due at cycle %0d", cyc);
            errors++;
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
        end
    end

    initial begin
        int idx;
        I_RST_N     = 1'b0;
        blk_start_i = 1'b0;
        score_vld_i = 1'b0;
        score_i     = '0;
        idx         = 0;
        void'($urandom(32'hef16));
        clear_model();
        repeat (RST_CYC) @(negedge I_CLK);
        I_RST_N = 1'b1;

        repeat (IDLE_CYC) drive_cycle(1'b0, 1'b0, '0);    // quiet after reset
        send_tile(MODE_MIX, 1'b0);                         // first tile, extremes
        drive_cycle(1'b1, 1'b0, '0);                       // block start alone
        drive_cycle(1'b0, 1'b0, '0);
        send_tile(MODE_MID, 1'b0);
        send_tile(MODE_LARGE, 1'b0);                       // max grows
        send_tile(MODE_SMALL, 1'b0);                       // max holds
        send_tile(MODE_MID, 1'b1);                         // start with a row

        for (int k = 0; k < N_RAND; k++) begin
            if ($urandom % 4 != 0) idx = int'($urandom % `ATTN_ROWS);   // else repeat index
            drive_cycle(1'b0, 1'b1, gen_row(idx, int'($urandom % 4)));
            if ($urandom % 4 == 0) drive_cycle(1'b0, 1'b0, '0);
        end
        drive_cycle(1'b0, 1'b0, '0);

        while (exp_q.size() != 0) @(negedge I_CLK);
        repeat (TAIL_CYC) @(negedge I_CLK);
        $display("%0d rows checked, %0d errors", n_checked, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+.
attn_pkg.sv
score_dispatch.sv
row_softmax.sv
prob_collect.sv
attn_softmax_top.sv
attn_softmax_checker.sv
tb_attn_softmax.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing -Wall
TOP       = tb_attn_softmax
FILELIST  = compile.f
OBJDIR    = obj_dir

.PHONY: all lint clean

all:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | awk '{ print } /Simulation finished: PASS/ { ok = 1 } END { exit !ok }'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
